// ==== src/tlp_align_cfg.svh ====
// ==============================
// TLP aligner configuration
// ==============================

`ifndef TLP_ALIGN_CFG_SVH
`define TLP_ALIGN_CFG_SVH

// Number of TLP slots carried by one input beat
`define TLP_IN_CH 2

// Number of TLP slots carried by one output beat
`define TLP_OUT_CH 4

// Width of the data word in every slot
`define TLP_DATA_W 32

`endif

// ==== src/tlp_kind_pkg.sv ====
// ==============================
// TLP kind and sideband types
// ==============================

package tlp_kind_pkg;

    // Coarse classification of a TLP, carried with every slot of it
    typedef enum logic [1:0] {
        mem_read   = 2'd0,
        mem_write  = 2'd1,
        completion = 2'd2,
        message    = 2'd3
    } tlp_kind_t;

    // Sideband that travels next to the data word of each slot
    typedef struct packed {
        tlp_kind_t  kind;
        // Request tag, opaque to the aligner
        logic [3:0] tag;
    } tlp_user_t;

endpackage

// ==== src/tlp_slot_pkg.sv ====
// ==============================
// TLP slot vector types
// ==============================

`include "tlp_align_cfg.svh"

package tlp_slot_pkg;

    import tlp_kind_pkg::*;

    // One slot of a stream beat
    // Flags are meaningful only while valid is set
    typedef struct packed {
        logic                   valid;
        logic                   sop;
        logic                   eop;
        logic [`TLP_DATA_W-1:0] data;
        tlp_user_t              user;
    } tlp_slot_t;

    // Slot vectors on the narrow input and the wide output side
    typedef tlp_slot_t [`TLP_IN_CH-1:0]  tlp_in_vec_t;
    typedef tlp_slot_t [`TLP_OUT_CH-1:0] tlp_out_vec_t;

    // Index into the aligner work register
    // The extra bit lets it name the position one past the last work slot
    typedef logic [$clog2(`TLP_IN_CH + `TLP_OUT_CH - 1):0] work_idx_t;

endpackage

// ==== src/tlp_stream_if.sv ====
// ==============================
// TLP slot stream interface
// ==============================

`timescale 1ns/1ps

// Valid/ready stream of slot vectors
// A beat moves on a rising clock edge with valid and ready both high
// The source holds valid and slots stable until the beat has moved
interface tlp_stream_if #(
    parameter type slot_vec_t = logic
) (
    input logic clk
);

    logic      valid;
    logic      ready;
    slot_vec_t slots;

    // Producer side of the stream
    modport source (
        input  clk,
        input  ready,
        output valid,
        output slots
    );

    // Consumer side of the stream
    modport sink (
        input  clk,
        input  valid,
        input  slots,
        output ready
    );

endinterface

// ==== src/tlp_ready_enable_reg.sv ====
// ==============================
// Valid/ready pipeline register
// ==============================

`timescale 1ns/1ps

module tlp_ready_enable_reg #(
    parameter type data_t = logic
) (
    input  logic  clk,
    input  logic  reset_n,

    input  logic  enable_from_src,
    input  data_t data_from_src,
    output logic  ready_to_src,

    output logic  enable_to_dst,
    output data_t data_to_dst,
    input  logic  ready_from_dst
);

    // The stage can take a new entry when it is empty or being drained
    assign ready_to_src = !enable_to_dst || ready_from_dst;

    // Occupancy flag of the single entry
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            enable_to_dst <= 1'b0;
        end
        else if (ready_to_src)
        begin
            enable_to_dst <= enable_from_src;
        end
    end

    // Payload follows the flag, whatever the source offers is taken
    always_ff @(posedge clk)
    begin
        if (ready_to_src)
        begin
            data_to_dst <= data_from_src;
        end
    end

endmodule

// ==== src/tlp_skid_buffer.sv ====
// ==============================
// Two-entry skid buffer
// ==============================

`timescale 1ns/1ps

module tlp_skid_buffer
    import tlp_slot_pkg::*;
(
    input logic          clk,
    input logic          reset_n,
    tlp_stream_if.sink   src,
    tlp_stream_if.source dst
);

    // Entry 0 is always the oldest held beat
    tlp_in_vec_t entry_q [2];
    logic [1:0]  count_q;
    logic [1:0]  count_after_pop;
    logic [1:0]  count_next;
    logic        ready_q;
    logic        in_xfer;
    logic        out_xfer;
    logic        push;
    logic        pop;

    // Ready toward the source is a flop, so no path crosses this stage
    assign src.ready = ready_q;

    // When nothing is held the input beat goes straight through
    assign dst.valid = (count_q != 2'd0) || src.valid;
    assign dst.slots = (count_q != 2'd0) ? entry_q[0] : src.slots;

    assign in_xfer  = src.valid && ready_q;
    assign out_xfer = dst.valid && dst.ready;

    // A pass-through beat never enters the buffer
    assign pop  = out_xfer && (count_q != 2'd0);
    assign push = in_xfer && !(out_xfer && (count_q == 2'd0));

    assign count_after_pop = count_q - 2'(pop);
    assign count_next      = count_after_pop + 2'(push);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count_q <= 2'd0;
            ready_q <= 1'b1;
        end
        else
        begin
            count_q <= count_next;
            ready_q <= (count_next != 2'd2);
        end
    end

    // Ready is low while two beats are held, so push and shift never collide
    always_ff @(posedge clk)
    begin
        if (pop && (count_q == 2'd2))
        begin
            entry_q[0] <= entry_q[1];
        end
        if (push)
        begin
            if (count_after_pop == 2'd0)
            begin
                entry_q[0] <= src.slots;
            end
            else
            begin
                entry_q[1] <= src.slots;
            end
        end
    end

endmodule

// ==== src/tlp_slot_packer.sv ====
// ==============================
// Dense slot packer
// ==============================

`timescale 1ns/1ps

`include "tlp_align_cfg.svh"

module tlp_slot_packer
    import tlp_slot_pkg::*;
(
    input logic          clk,
    input logic          reset_n,
    tlp_stream_if.sink   src,
    tlp_stream_if.source dst
);

    // Wide enough to count every slot of the input beat
    typedef logic [$clog2(`TLP_IN_CH + 1)-1:0] pack_idx_t;

    pack_idx_t   tgt_idx [`TLP_IN_CH];
    pack_idx_t   num_valid;
    logic        any_valid;
    tlp_in_vec_t dense_slots;

    // ==============================
    // Target position of each slot
    // ==============================

    // A slot lands at the number of valid slots below it
    always_comb
    begin
        num_valid = '0;
        for (int i = 0; i < `TLP_IN_CH; i++)
        begin
            tgt_idx[i] = num_valid;
            num_valid  = num_valid + pack_idx_t'(src.slots[i].valid);
        end
    end

    assign any_valid = (num_valid != '0);

    // Invalid slots are rebuilt as all zero, which also drops junk sop and eop
    always_comb
    begin
        dense_slots = '0;
        for (int i = 0; i < `TLP_IN_CH; i++)
        begin
            if (src.slots[i].valid)
            begin
                dense_slots[tgt_idx[i]] = src.slots[i];
            end
        end
    end

    // ==============================
    // Output register
    // ==============================

    // An empty beat is still accepted, it just never sets the enable
    tlp_ready_enable_reg #(
        .data_t(tlp_in_vec_t)
    ) u_dense_reg (
        .clk             (clk),
        .reset_n         (reset_n),
        .enable_from_src (src.valid && any_valid),
        .data_from_src   (dense_slots),
        .ready_to_src    (src.ready),
        .enable_to_dst   (dst.valid),
        .data_to_dst     (dst.slots),
        .ready_from_dst  (dst.ready)
    );

endmodule

// ==== src/tlp_slot_aligner.sv ====
// ==============================
// Slot aligner shift register
// ==============================

`timescale 1ns/1ps

`include "tlp_align_cfg.svh"

module tlp_slot_aligner
    import tlp_slot_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    tlp_stream_if.sink   src,
    output logic         out_valid,
    input  logic         out_ready,
    output tlp_out_vec_t out_slots
);

    localparam int WORK_CH = `TLP_IN_CH + `TLP_OUT_CH - 1;

    // Valid entries are always packed densely from slot 0
    tlp_slot_t           work_q [WORK_CH];
    tlp_slot_t           merged [WORK_CH];
    tlp_slot_t           work_d [WORK_CH];
    logic [WORK_CH-1:0]  merged_valid;
    logic [WORK_CH-1:0]  merged_eop;
    logic [`TLP_OUT_CH-1:0] out_mask;
    work_idx_t           first_invalid;
    work_idx_t           out_num;
    logic                work_full;
    logic                in_xfer;
    logic                work_out_valid;
    logic                work_out_ready;
    logic                out_xfer;
    tlp_out_vec_t        out_wires;

    // With the output portion full a beat is always pending, so new slots wait
    // There is then room for a whole input beat whenever ready is high
    assign work_full = work_q[`TLP_OUT_CH-1].valid;
    assign src.ready = !work_full;
    assign in_xfer   = src.valid && !work_full;

    // First free work slot, where the incoming dense slots are appended
    always_comb
    begin
        first_invalid = work_idx_t'(WORK_CH);
        for (int i = WORK_CH - 1; i >= 0; i--)
        begin
            if (!work_q[i].valid)
            begin
                first_invalid = work_idx_t'(i);
            end
        end
    end

    // Work register as seen with this cycle's input beat added
    always_comb
    begin
        merged = work_q;
        if (in_xfer)
        begin
            for (int i = 0; i < `TLP_IN_CH; i++)
            begin
                merged[first_invalid + i] = src.slots[i];
            end
        end
        for (int i = 0; i < WORK_CH; i++)
        begin
            merged_valid[i] = merged[i].valid;
            merged_eop[i]   = merged[i].eop;
        end
    end

    // ==============================
    // Outbound beat selection
    // ==============================

    // Offer a beat once the low slots are all valid or a packet ends there
    assign work_out_valid = (&merged_valid[`TLP_OUT_CH-1:0]) ||
                            (|merged_eop[`TLP_OUT_CH-1:0]);

    // Slots up to and including the first eop leave together
    always_comb
    begin
        out_num = work_idx_t'(`TLP_OUT_CH);
        for (int i = `TLP_OUT_CH - 1; i >= 0; i--)
        begin
            if (!merged_valid[i])
            begin
                out_num = work_idx_t'(i);
            end
            else if (merged_eop[i])
            begin
                out_num = work_idx_t'(i + 1);
            end
        end
        out_mask[0] = merged_valid[0];
        for (int i = 1; i < `TLP_OUT_CH; i++)
        begin
            out_mask[i] = merged_valid[i] && out_mask[i-1] && !merged_eop[i-1];
        end
        for (int i = 0; i < `TLP_OUT_CH; i++)
        begin
            out_wires[i] = out_mask[i] ? merged[i] : '0;
        end
    end

    assign out_xfer = work_out_valid && work_out_ready;

    // Remaining slots shift down by the number that left
    always_comb
    begin
        for (int i = 0; i < WORK_CH; i++)
        begin
            work_d[i] = merged[i];
            if (out_xfer)
            begin
                work_d[i] = '0;
                if (i + out_num < WORK_CH)
                begin
                    work_d[i] = merged[i + out_num];
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        work_q <= work_d;
        if (!reset_n)
        begin
            for (int i = 0; i < WORK_CH; i++)
            begin
                work_q[i].valid <= 1'b0;
                work_q[i].sop   <= 1'b0;
                work_q[i].eop   <= 1'b0;
            end
        end
    end

    tlp_ready_enable_reg #(
        .data_t(tlp_out_vec_t)
    ) u_out_reg (
        .clk             (clk),
        .reset_n         (reset_n),
        .enable_from_src (work_out_valid),
        .data_from_src   (out_wires),
        .ready_to_src    (work_out_ready),
        .enable_to_dst   (out_valid),
        .data_to_dst     (out_slots),
        .ready_from_dst  (out_ready)
    );

endmodule

// ==== src/tlp_align_top.sv ====
// ==============================
// TLP slot aligner top
// ==============================

`timescale 1ns/1ps

module tlp_align_top
    import tlp_slot_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  logic         in_valid,
    output logic         in_ready,
    input  tlp_in_vec_t  in_slots,
    output logic         out_valid,
    input  logic         out_ready,
    output tlp_out_vec_t out_slots
);

    // Stream links between the stages
    tlp_stream_if #(.slot_vec_t(tlp_in_vec_t)) in_if    (.clk(clk));
    tlp_stream_if #(.slot_vec_t(tlp_in_vec_t)) skid_if  (.clk(clk));
    tlp_stream_if #(.slot_vec_t(tlp_in_vec_t)) dense_if (.clk(clk));

    // Top level pins onto the input link
    assign in_if.valid = in_valid;
    assign in_if.slots = in_slots;
    assign in_ready    = in_if.ready;

    tlp_skid_buffer u_skid (
        .clk     (clk),
        .reset_n (reset_n),
        .src     (in_if.sink),
        .dst     (skid_if.source)
    );

    tlp_slot_packer u_packer (
        .clk     (clk),
        .reset_n (reset_n),
        .src     (skid_if.sink),
        .dst     (dense_if.source)
    );

    tlp_slot_aligner u_aligner (
        .clk       (clk),
        .reset_n   (reset_n),
        .src       (dense_if.sink),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_slots (out_slots)
    );

endmodule

// ==== verification/tlp_align_tb.sv ====
// ==============================
// TLP slot aligner testbench
// ==============================

`timescale 1ns/1ps

`include "tlp_align_cfg.svh"

module tlp_align_tb
    import tlp_kind_pkg::*;
    import tlp_slot_pkg::*;
();

    localparam int NUM_PKT = 200;

    logic         clk;
    logic         reset_n;
    logic         in_valid;
    logic         in_ready;
    tlp_in_vec_t  in_slots;
    logic         out_valid;
    logic         out_ready;
    tlp_out_vec_t out_slots;

    // Packets still to be driven, and valid slots still due at the output
    tlp_slot_t    gen_q [$];
    tlp_slot_t    exp_q [$];
    int           total_slots;
    int           cycle_cnt;
    int           cycle_limit;
    int           stall_cnt;
    logic         held_valid;
    tlp_out_vec_t held_slots;

    tlp_align_top u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_slots  (in_slots),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_slots (out_slots)
    );

    task automatic stop_on_error();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Expected beat: slots in order up to the first eop or a full output beat
    function automatic tlp_out_vec_t next_expected_beat(input tlp_slot_t q [$],
                                                        output int taken);
        tlp_out_vec_t beat;
        beat  = '0;
        taken = 0;
        for (int i = 0; i < `TLP_OUT_CH && i < q.size(); i++)
        begin
            beat[i] = q[i];
            taken   = i + 1;
            if (q[i].eop)
            begin
                break;
            end
        end
        return beat;
    endfunction

    // Invalid slot with random flags that the DUT has to clear
    function automatic tlp_slot_t make_junk_slot();
        tlp_slot_t junk;
        junk.valid     = 1'b0;
        junk.sop       = 1'($urandom_range(1));
        junk.eop       = 1'($urandom_range(1));
        junk.data      = $urandom;
        junk.user.kind = tlp_kind_t'($urandom_range(3));
        junk.user.tag  = 4'($urandom_range(15));
        return junk;
    endfunction

    // Output stream rules: sop only in slot 0, no gaps, nothing after an eop
    task automatic check_beat_rules(input tlp_out_vec_t beat);
        logic after_eop;
        after_eop = 1'b0;
        assert (beat[0].valid)
        else
        begin
            $display("Output beat has an empty slot 0: %h", beat);
            stop_on_error();
        end
        for (int i = 0; i < `TLP_OUT_CH; i++)
        begin
            if (i > 0)
            begin
                assert (!beat[i].sop && (!beat[i].valid || beat[i-1].valid))
                else
                begin
                    $display("Slot %0d has a sop or follows a gap: %h", i, beat);
                    stop_on_error();
                end
            end
            assert (!(after_eop && beat[i].valid) &&
                    (beat[i].valid || !(beat[i].sop || beat[i].eop)))
            else
            begin
                $display("Slot %0d is filled after an eop or flags an empty slot: %h", i, beat);
                stop_on_error();
            end
            after_eop = after_eop | beat[i].eop;
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    // Run length limit, derived from the number of generated slots
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
        begin
            $display("Timeout: the output did not drain within %0d cycles", cycle_limit);
            stop_on_error();
        end
    end

    // Every valid slot accepted at the input is due at the output in order
    always @(negedge clk)
    begin
        if (reset_n && in_valid && in_ready)
        begin
            for (int i = 0; i < `TLP_IN_CH; i++)
            begin
                if (in_slots[i].valid)
                begin
                    exp_q.push_back(in_slots[i]);
                end
            end
        end
    end

    // Comparison of each accepted output beat against the reference beat
    always @(negedge clk)
    begin
        tlp_out_vec_t exp_beat;
        int           taken;
        if (reset_n && out_valid && out_ready)
        begin
            exp_beat = next_expected_beat(exp_q, taken);
            assert (taken > 0)
            else
            begin
                $display("An output beat arrived while no slot was expected");
                stop_on_error();
            end
            check_beat_rules(out_slots);
            for (int i = 0; i < `TLP_OUT_CH; i++)
            begin
                assert (out_slots[i] === exp_beat[i])
                else
                begin
                    $display("[FAIL] out_slots[%0d]: expected %h, got %h",
                             i, exp_beat[i], out_slots[i]);
                    stop_on_error();
                end
            end
            repeat (taken) void'(exp_q.pop_front());
        end
    end

    // A stalled beat has to stay in place until it is taken
    always @(negedge clk)
    begin
        if (held_valid)
        begin
            assert (out_valid && out_slots === held_slots)
            else
            begin
                $display("[FAIL] out_slots: expected %h, got %h (out_valid %h)",
                         held_slots, out_slots, out_valid);
                stop_on_error();
            end
        end
        held_valid = reset_n && out_valid && !out_ready;
        held_slots = out_slots;
    end

    // Random back-pressure with occasional long stalls
    initial
    begin
        @(posedge reset_n);
        forever
        begin
            @(posedge clk);
            #1;
            if (stall_cnt > 0)
            begin
                stall_cnt = stall_cnt - 1;
                out_ready = 1'b0;
            end
            else if ($urandom_range(19) == 0)
            begin
                stall_cnt = $urandom_range(30, 10);
                out_ready = 1'b0;
            end
            else
            begin
                out_ready = ($urandom_range(3) != 0);
            end
        end
    end

    initial
    begin
        int        len;
        tlp_slot_t slot;
        logic      xfer;
        logic      empty_beat;
        reset_n       = 1'b0;
        in_valid      = 1'b0;
        in_slots      = '0;
        out_ready     = 1'b0;
        cycle_cnt     = 0;
        cycle_limit   = 0;
        stall_cnt     = 0;
        held_valid    = 1'b0;
        void'($urandom(31));

        // ==============================
        // Packet generation
        // ==============================
        for (int p = 0; p < NUM_PKT; p++)
        begin
            len            = $urandom_range(9, 1);
            slot.valid     = 1'b1;
            slot.user.kind = tlp_kind_t'($urandom_range(3));
            slot.user.tag  = 4'($urandom_range(15));
            for (int s = 0; s < len; s++)
            begin
                slot.sop  = (s == 0);
                slot.eop  = (s == len - 1);
                slot.data = $urandom;
                gen_q.push_back(slot);
            end
        end
        total_slots = gen_q.size();
        cycle_limit = 40 * total_slots;

        repeat (5) @(posedge clk);
        #1 reset_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && in_ready)
        else
        begin
            $display("[FAIL] after reset: out_valid %h, in_ready %h", out_valid, in_ready);
            stop_on_error();
        end

        // ==============================
        // Beat driver
        // ==============================
        @(posedge clk);
        #1;
        while (gen_q.size() > 0)
        begin
            if ($urandom_range(3) == 0)
            begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
                continue;
            end
            // Some beats carry junk only and must vanish inside the DUT
            empty_beat = ($urandom_range(7) == 0);
            for (int i = 0; i < `TLP_IN_CH; i++)
            begin
                if (!empty_beat && gen_q.size() > 0 && $urandom_range(2) != 0)
                begin
                    in_slots[i] = gen_q.pop_front();
                end
                else
                begin
                    in_slots[i] = make_junk_slot();
                end
            end
            in_valid = 1'b1;
            // in_ready is a flop, so its value here decides the next edge
            do
            begin
                xfer = in_ready;
                @(posedge clk);
                #1;
            end
            while (!xfer);
        end
        in_valid = 1'b0;

        // All slots are out, so no further beat may be offered
        wait (exp_q.size() == 0);
        repeat (20) @(negedge clk);
        if (!out_valid)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("An output beat is left over after every slot was checked");
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tlp_align_top.f ====
+incdir+src
src/tlp_kind_pkg.sv
src/tlp_slot_pkg.sv
src/tlp_stream_if.sv
src/tlp_ready_enable_reg.sv
src/tlp_skid_buffer.sv
src/tlp_slot_packer.sv
src/tlp_slot_aligner.sv
src/tlp_align_top.sv
verification/tlp_align_tb.sv
